//--- autotest_pkg.sv
// autotest package
// sizes, sector record layout and sequencer state encoding for the
// block cipher self-test controller
`default_nettype none

package autotest_pkg;

  // UUT data widths
  localparam int BLOCK_BITS  = 64;
  localparam int KEY_BITS    = 80;
  localparam int BLOCK_BYTES = BLOCK_BITS / 8;
  localparam int KEY_BYTES   = KEY_BITS / 8;

  localparam int SECTOR_BYTES = 512;

  // byte offsets within the vector and report sector
  localparam int OFS_SIGNATURE = 0;
  localparam int OFS_TAG       = 4;
  localparam int OFS_BLOCK     = 5;
  localparam int OFS_KEY       = 13;
  localparam int OFS_ENCDEC    = 23;
  localparam int OFS_EXPECTED  = 24;
  localparam int OFS_RESULT    = 32;
  localparam int OFS_EXEC      = 40;

  localparam int EXEC_BITS = 32;

  // report bytes past this point are zero
  localparam int REPORT_BYTES = OFS_EXEC + EXEC_BITS / 8;

  localparam logic [31:0] RECORD_SIGNATURE = 32'hAABB_CCDD;
  localparam logic [31:0] START_BLOCK      = 32'h0010_0000;

  // encoding is visible in the debug word
  typedef enum logic [3:0] {
    ST_INIT     = 4'd0,
    ST_SD_RESET = 4'd1,
    ST_SD_WAIT  = 4'd2,
    ST_LOAD     = 4'd3,
    ST_CHECK    = 4'd4,
    ST_RUN      = 4'd5,
    ST_COMPARE  = 4'd6,
    ST_REPORT   = 4'd7,
    ST_NEXT     = 4'd8,
    ST_HALT     = 4'd9
  } seq_state_t;

endpackage

`default_nettype wire

//--- sd_host_if.sv
// SD host byte port
// one client side of the shared SD/SPI host, seen through the arbiter
`timescale 1ns/1ps
`default_nettype none

interface sd_host_if;

  logic       req;
  logic       r_block;
  logic       w_block;
  logic       r_byte;
  logic       w_byte;
  logic [7:0] data_in;

  logic       gnt;
  logic       busy;
  logic [7:0] data_out;

  modport client (
    output req, r_block, w_block, r_byte, w_byte, data_in,
    input  gnt, busy, data_out
  );

  modport arbiter (
    input  req, r_block, w_block, r_byte, w_byte, data_in,
    output gnt, busy, data_out
  );

endinterface

`default_nettype wire

//--- sd_port_arbiter.sv
// SD port arbiter
// grants the single SD host byte port to the vector loader or the
// result reporter and forwards the owner's strobes and data
`timescale 1ns/1ps
`default_nettype none

module sd_port_arbiter (
  input  logic       clk,
  input  logic       rst,
  sd_host_if.arbiter loader_port,
  sd_host_if.arbiter reporter_port,
  input  logic       spi_busy_i,
  input  logic [7:0] spi_data_out_i,
  output logic       spi_r_block_o,
  output logic       spi_r_byte_o,
  output logic       spi_w_block_o,
  output logic       spi_w_byte_o,
  output logic [7:0] spi_data_in_o
);

  logic own_ld;
  logic own_rp;

  // owner holds the port until its req falls, loader wins a tie
  always_ff @(posedge clk) begin
    if (rst) begin
      own_ld <= 1'b0;
      own_rp <= 1'b0;
    end else if (own_ld) begin
      own_ld <= loader_port.req;
    end else if (own_rp) begin
      own_rp <= reporter_port.req;
    end else if (loader_port.req) begin
      own_ld <= 1'b1;
    end else if (reporter_port.req) begin
      own_rp <= 1'b1;
    end
  end

  assign loader_port.gnt   = own_ld;
  assign reporter_port.gnt = own_rp;

  // a client without the grant just sees a busy host
  assign loader_port.busy   = own_ld ? spi_busy_i : 1'b1;
  assign reporter_port.busy = own_rp ? spi_busy_i : 1'b1;

  assign loader_port.data_out   = own_ld ? spi_data_out_i : 8'h00;
  assign reporter_port.data_out = own_rp ? spi_data_out_i : 8'h00;

  always_comb begin
    spi_r_block_o = 1'b0;
    spi_r_byte_o  = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o  = 1'b0;
    spi_data_in_o = 8'h00;
    if (own_ld) begin
      spi_r_block_o = loader_port.r_block;
      spi_r_byte_o  = loader_port.r_byte;
      spi_w_block_o = loader_port.w_block;
      spi_w_byte_o  = loader_port.w_byte;
      spi_data_in_o = loader_port.data_in;
    end else if (own_rp) begin
      spi_r_block_o = reporter_port.r_block;
      spi_r_byte_o  = reporter_port.r_byte;
      spi_w_block_o = reporter_port.w_block;
      spi_w_byte_o  = reporter_port.w_byte;
      spi_data_in_o = reporter_port.data_in;
    end
  end

endmodule

`default_nettype wire

//--- vector_loader.sv
// vector loader
// reads one test-vector sector byte by byte over the SD host port and
// fills the signature, tag, block, key, direction and expected registers
`timescale 1ns/1ps
`default_nettype none

module vector_loader
  import autotest_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,
  sd_host_if.client             sd,
  output logic                  done_o,
  output logic [31:0]           signature_o,
  output logic [7:0]            tag_o,
  output logic [BLOCK_BITS-1:0] block_o,
  output logic [KEY_BITS-1:0]   key_o,
  output logic                  encdec_o,
  output logic [BLOCK_BITS-1:0] expected_o
);

  logic       active;
  logic       opened;
  logic       hs_wait;
  logic [8:0] byte_cnt;
  logic       byte_done;

  assign sd.req     = active;
  assign sd.r_block = active;
  assign sd.r_byte  = active && opened && !hs_wait;
  assign sd.w_block = 1'b0;
  assign sd.w_byte  = 1'b0;
  assign sd.data_in = 8'h00;

  // busy has fallen after an accepted byte request
  assign byte_done = active && opened && hs_wait && !sd.busy;

  // block open and each byte both wait for busy high, then low
  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      opened   <= 1'b0;
      hs_wait  <= 1'b0;
      byte_cnt <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        active   <= 1'b1;
        opened   <= 1'b0;
        hs_wait  <= 1'b0;
        byte_cnt <= '0;
      end else if (active) begin
        if (!hs_wait) begin
          if (sd.gnt && sd.busy) begin
            hs_wait <= 1'b1;
          end
        end else if (!sd.busy) begin
          hs_wait <= 1'b0;
          opened  <= 1'b1;
          if (opened) begin
            byte_cnt <= byte_cnt + 9'd1;
            if (byte_cnt == 9'(SECTOR_BYTES - 1)) begin
              active <= 1'b0;
              done_o <= 1'b1;
            end
          end
        end
      end
    end
  end

  // signature arrives msb first, other fields lsb first
  always_ff @(posedge clk) begin
    if (start_i) begin
      signature_o <= '0;
      tag_o       <= '0;
      block_o     <= '0;
      key_o       <= '0;
      encdec_o    <= 1'b0;
      expected_o  <= '0;
    end else if (byte_done) begin
      if (byte_cnt < OFS_TAG) begin
        signature_o <= {signature_o[23:0], sd.data_out};
      end else if (byte_cnt == OFS_TAG) begin
        tag_o <= sd.data_out;
      end else if (byte_cnt < OFS_BLOCK + BLOCK_BYTES) begin
        block_o <= {sd.data_out, block_o[BLOCK_BITS-1:8]};
      end else if (byte_cnt < OFS_KEY + KEY_BYTES) begin
        key_o <= {sd.data_out, key_o[KEY_BITS-1:8]};
      end else if (byte_cnt == OFS_ENCDEC) begin
        encdec_o <= sd.data_out[0];
      end else if (byte_cnt < OFS_EXPECTED + BLOCK_BYTES) begin
        expected_o <= {sd.data_out, expected_o[BLOCK_BITS-1:8]};
      end
    end
  end

endmodule

`default_nettype wire

//--- result_reporter.sv
// result reporter
// writes the 512-byte report sector: signature, echoed record, UUT
// result and execution count, zeros elsewhere
`timescale 1ns/1ps
`default_nettype none

module result_reporter
  import autotest_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,
  sd_host_if.client             sd,
  output logic                  done_o,
  input  logic [7:0]            tag_i,
  input  logic [BLOCK_BITS-1:0] block_i,
  input  logic [KEY_BITS-1:0]   key_i,
  input  logic                  encdec_i,
  input  logic [BLOCK_BITS-1:0] expected_i,
  input  logic [BLOCK_BITS-1:0] result_i,
  input  logic [EXEC_BITS-1:0]  exec_cycles_i
);

  logic                      active;
  logic                      opened;
  logic                      hs_wait;
  logic [8:0]                byte_cnt;
  logic [8:0]                next_cnt;
  logic [7:0]                data_q;
  logic [7:0]                next_byte;
  logic                      byte_done;
  logic [8*REPORT_BYTES-1:0] image;

  // byte k of the report sits at image bits 8k+7:8k
  assign image = {exec_cycles_i, result_i, expected_i, 7'b0, encdec_i, key_i, block_i,
                  tag_i, RECORD_SIGNATURE[7:0], RECORD_SIGNATURE[15:8],
                  RECORD_SIGNATURE[23:16], RECORD_SIGNATURE[31:24]};

  assign next_cnt  = start_i ? 9'd0 : byte_cnt + 9'd1;
  assign next_byte = (next_cnt < REPORT_BYTES) ? image[8*next_cnt +: 8] : 8'h00;

  assign sd.req     = active;
  assign sd.w_block = active;
  assign sd.w_byte  = active && opened && !hs_wait;
  assign sd.r_block = 1'b0;
  assign sd.r_byte  = 1'b0;
  assign sd.data_in = data_q;

  assign byte_done = active && opened && hs_wait && !sd.busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      opened   <= 1'b0;
      hs_wait  <= 1'b0;
      byte_cnt <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        active   <= 1'b1;
        opened   <= 1'b0;
        hs_wait  <= 1'b0;
        byte_cnt <= '0;
      end else if (active) begin
        if (!hs_wait) begin
          if (sd.gnt && sd.busy) begin
            hs_wait <= 1'b1;
          end
        end else if (!sd.busy) begin
          hs_wait <= 1'b0;
          opened  <= 1'b1;
          if (opened) begin
            byte_cnt <= next_cnt;
            if (byte_cnt == 9'(SECTOR_BYTES - 1)) begin
              active <= 1'b0;
              done_o <= 1'b1;
            end
          end
        end
      end
    end
  end

  // next byte is staged as soon as the previous one completes
  always_ff @(posedge clk) begin
    if (start_i || byte_done) begin
      data_q <= next_byte;
    end
  end

endmodule

`default_nettype wire

//--- autotest_sequencer.sv
// autotest sequencer
// main FSM: SD reset, vector load, signature check, UUT run, compare,
// report and block advance, plus the debug view
`timescale 1ns/1ps
`default_nettype none

module autotest_sequencer
  import autotest_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  spi_busy_i,
  output logic                  spi_rst_o,
  output logic [31:0]           block_addr_o,
  output logic                  load_start_o,
  input  logic                  load_done_i,
  output logic                  report_start_o,
  input  logic                  report_done_i,
  input  logic [31:0]           signature_i,
  input  logic                  encdec_i,
  input  logic [BLOCK_BITS-1:0] expected_i,
  input  logic [BLOCK_BITS-1:0] block_o_uut_i,
  input  logic                  end_enc_uut_i,
  input  logic                  end_dec_uut_i,
  output logic                  rst_uut_o,
  output logic [BLOCK_BITS-1:0] result_o,
  output logic [EXEC_BITS-1:0]  exec_cycles_o,
  input  logic [1:0]            sw_debug_i,
  output logic [31:0]           debug_o
);

  seq_state_t           state;
  logic [31:0]          block_q;
  logic [31:0]          err_cnt;
  logic [EXEC_BITS-1:0] timer;
  logic                 end_flag;

  assign end_flag      = encdec_i ? end_dec_uut_i : end_enc_uut_i;
  assign spi_rst_o     = (state == ST_SD_RESET);
  assign block_addr_o  = block_q;
  assign exec_cycles_o = timer;

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= ST_INIT;
      block_q        <= START_BLOCK;
      err_cnt        <= '0;
      timer          <= '0;
      rst_uut_o      <= 1'b1;
      load_start_o   <= 1'b0;
      report_start_o <= 1'b0;
    end else begin
      load_start_o   <= 1'b0;
      report_start_o <= 1'b0;
      case (state)
        ST_INIT: state <= ST_SD_RESET;
        ST_SD_RESET: begin
          if (spi_busy_i) begin
            state <= ST_SD_WAIT;
          end
        end
        ST_SD_WAIT: begin
          if (!spi_busy_i) begin
            state        <= ST_LOAD;
            load_start_o <= 1'b1;
          end
        end
        ST_LOAD: begin
          if (load_done_i) begin
            state <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          if (signature_i == RECORD_SIGNATURE) begin
            state     <= ST_RUN;
            rst_uut_o <= 1'b0;
            timer     <= '0;
          end else begin
            state <= ST_HALT;
          end
        end
        // timer holds the cycle count at which the end flag was seen
        ST_RUN: begin
          if (end_flag) begin
            state <= ST_COMPARE;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        ST_COMPARE: begin
          if (result_o != expected_i) begin
            err_cnt <= err_cnt + 32'd1;
          end
          state          <= ST_REPORT;
          report_start_o <= 1'b1;
        end
        ST_REPORT: begin
          if (report_done_i) begin
            state <= ST_NEXT;
          end
        end
        ST_NEXT: begin
          block_q      <= block_q + 32'd1;
          rst_uut_o    <= 1'b1;
          state        <= ST_LOAD;
          load_start_o <= 1'b1;
        end
        default: state <= ST_HALT;
      endcase
    end
  end

  // uut output captured in the cycle the end flag is sampled
  always_ff @(posedge clk) begin
    if (state == ST_RUN && end_flag) begin
      result_o <= block_o_uut_i;
    end
  end

  always_comb begin
    case (sw_debug_i)
      2'd0:    debug_o = {block_q[15:0], 12'h000, state};
      2'd1:    debug_o = err_cnt;
      2'd2:    debug_o = timer;
      default: debug_o = block_q;
    endcase
  end

endmodule

`default_nettype wire

//--- autotest_top.sv
// autotest top level
// self-test controller for a 64-bit block cipher, driven by test vectors
// read from and reported back to an SD card
`timescale 1ns/1ps
`default_nettype none

module autotest_top
  import autotest_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  spi_busy_i,
  input  logic [7:0]            spi_data_out_i,
  // kept for pin compatibility with the SD host
  input  logic                  spi_err_i,
  input  logic                  spi_crc_err_i,
  output logic [31:0]           spi_block_addr_o,
  output logic                  spi_r_block_o,
  output logic                  spi_r_byte_o,
  output logic                  spi_w_block_o,
  output logic                  spi_w_byte_o,
  output logic                  spi_rst_o,
  output logic [7:0]            spi_data_in_o,
  output logic                  rst_uut_o,
  output logic [BLOCK_BITS-1:0] block_i_uut_o,
  output logic [KEY_BITS-1:0]   key_uut_o,
  output logic                  encdec_uut_o,
  input  logic [BLOCK_BITS-1:0] block_o_uut_i,
  input  logic                  end_enc_uut_i,
  input  logic                  end_dec_uut_i,
  input  logic [1:0]            sw_debug_i,
  output logic [31:0]           debug_o
);

  logic                  load_start;
  logic                  load_done;
  logic                  report_start;
  logic                  report_done;
  logic [31:0]           signature;
  logic [7:0]            tag;
  logic [BLOCK_BITS-1:0] expected;
  logic [BLOCK_BITS-1:0] result;
  logic [EXEC_BITS-1:0]  exec_cycles;

  sd_host_if loader_sd ();
  sd_host_if reporter_sd ();

  autotest_sequencer autotest_sequencer_i (
    .clk            (clk),
    .rst            (rst),
    .spi_busy_i     (spi_busy_i),
    .spi_rst_o      (spi_rst_o),
    .block_addr_o   (spi_block_addr_o),
    .load_start_o   (load_start),
    .load_done_i    (load_done),
    .report_start_o (report_start),
    .report_done_i  (report_done),
    .signature_i    (signature),
    .encdec_i       (encdec_uut_o),
    .expected_i     (expected),
    .block_o_uut_i  (block_o_uut_i),
    .end_enc_uut_i  (end_enc_uut_i),
    .end_dec_uut_i  (end_dec_uut_i),
    .rst_uut_o      (rst_uut_o),
    .result_o       (result),
    .exec_cycles_o  (exec_cycles),
    .sw_debug_i     (sw_debug_i),
    .debug_o        (debug_o)
  );

  vector_loader vector_loader_i (
    .clk         (clk),
    .rst         (rst),
    .start_i     (load_start),
    .sd          (loader_sd.client),
    .done_o      (load_done),
    .signature_o (signature),
    .tag_o       (tag),
    .block_o     (block_i_uut_o),
    .key_o       (key_uut_o),
    .encdec_o    (encdec_uut_o),
    .expected_o  (expected)
  );

  result_reporter result_reporter_i (
    .clk           (clk),
    .rst           (rst),
    .start_i       (report_start),
    .sd            (reporter_sd.client),
    .done_o        (report_done),
    .tag_i         (tag),
    .block_i       (block_i_uut_o),
    .key_i         (key_uut_o),
    .encdec_i      (encdec_uut_o),
    .expected_i    (expected),
    .result_i      (result),
    .exec_cycles_i (exec_cycles)
  );

  sd_port_arbiter sd_port_arbiter_i (
    .clk            (clk),
    .rst            (rst),
    .loader_port    (loader_sd.arbiter),
    .reporter_port  (reporter_sd.arbiter),
    .spi_busy_i     (spi_busy_i),
    .spi_data_out_i (spi_data_out_i),
    .spi_r_block_o  (spi_r_block_o),
    .spi_r_byte_o   (spi_r_byte_o),
    .spi_w_block_o  (spi_w_block_o),
    .spi_w_byte_o   (spi_w_byte_o),
    .spi_data_in_o  (spi_data_in_o)
  );

endmodule

`default_nettype wire

//--- tb_sd_card.sv
// behavioral SD host
// sector store addressed from the start block, busy timing on every
// block open and byte transfer, and a log of written sectors
`timescale 1ns/1ps
`default_nettype none

module tb_sd_card
  import autotest_pkg::*;
#(
  parameter int SECTORS = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        spi_rst_i,
  input  logic [31:0] block_addr_i,
  input  logic        r_block_i,
  input  logic        r_byte_i,
  input  logic        w_block_i,
  input  logic        w_byte_i,
  input  logic [7:0]  data_in_i,
  output logic        busy_o,
  output logic [7:0]  data_out_o,
  output int          write_count_o
);

  logic [7:0]  rmem [SECTORS*SECTOR_BYTES];
  logic [7:0]  wmem [SECTORS*SECTOR_BYTES];
  logic [31:0] wr_addr [SECTORS];
  logic [31:0] cur_addr;
  logic        r_block_q;
  logic        w_block_q;
  int          base;
  int          idx;
  int          busy_cnt;

  function automatic int sector_base(input logic [31:0] addr);
    logic [31:0] ofs;
    ofs = addr - START_BLOCK;
    if (ofs < SECTORS) begin
      return int'(ofs) * SECTOR_BYTES;
    end
    return -1;
  endfunction

  // mostly one busy cycle, every fourth byte takes two
  function automatic int busy_len(input int n);
    return (n % 4 == 3) ? 1 : 0;
  endfunction

  always @(negedge clk) begin
    if (rst) begin
      busy_o        <= 1'b0;
      busy_cnt      <= 0;
      data_out_o    <= 8'h00;
      r_block_q     <= 1'b0;
      w_block_q     <= 1'b0;
      base          <= -1;
      idx           <= 0;
      cur_addr      <= '0;
      write_count_o <= 0;
    end else begin
      r_block_q <= r_block_i;
      w_block_q <= w_block_i;
      if (busy_o) begin
        if (busy_cnt == 0) begin
          busy_o <= 1'b0;
        end else begin
          busy_cnt <= busy_cnt - 1;
        end
      end else if (spi_rst_i) begin
        busy_o   <= 1'b1;
        busy_cnt <= 4;
      end else if ((r_block_i && !r_block_q) || (w_block_i && !w_block_q)) begin
        // block open
        busy_o   <= 1'b1;
        busy_cnt <= 2;
        base     <= sector_base(block_addr_i);
        cur_addr <= block_addr_i;
        idx      <= 0;
      end else if (r_byte_i) begin
        if (base >= 0 && idx < SECTOR_BYTES) begin
          data_out_o <= rmem[base+idx];
        end else begin
          data_out_o <= 8'h00;
        end
        idx      <= idx + 1;
        busy_o   <= 1'b1;
        busy_cnt <= busy_len(idx);
      end else if (w_byte_i) begin
        if (base >= 0 && idx < SECTOR_BYTES) begin
          wmem[base+idx] <= data_in_i;
        end
        idx      <= idx + 1;
        busy_o   <= 1'b1;
        busy_cnt <= busy_len(idx);
      end
      // sector is logged when the write block closes
      if (!w_block_i && w_block_q) begin
        if (write_count_o < SECTORS) begin
          wr_addr[write_count_o] <= cur_addr;
        end
        write_count_o <= write_count_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_autotest.sv
// autotest testbench
// builds vector sectors from a table, models the UUT and checks the
// reports, error count and final halt of the controller
`timescale 1ns/1ps
`default_nettype none

module tb_autotest
  import autotest_pkg::*;
();

  localparam int ROWS = 6;
  localparam int WATCHDOG_CYCLES = 2 * ROWS * 2000 + 1000;

  // row direction, UUT latency, expected value right and signature valid
  localparam bit ROW_DEC  [ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
  localparam int ROW_LAT  [ROWS] = '{5, 12, 0, 7, 3, 4};
  localparam bit ROW_GOOD [ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
  localparam bit ROW_SIG  [ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

  logic                  clk;
  logic                  rst;
  logic                  spi_busy;
  logic [7:0]            spi_data_out;
  logic [31:0]           spi_block_addr;
  logic                  spi_r_block;
  logic                  spi_r_byte;
  logic                  spi_w_block;
  logic                  spi_w_byte;
  logic                  spi_rst;
  logic [7:0]            spi_data_in;
  logic                  rst_uut;
  logic [BLOCK_BITS-1:0] block_i_uut;
  logic [KEY_BITS-1:0]   key_uut;
  logic                  encdec_uut;
  logic [BLOCK_BITS-1:0] block_o_uut = '0;
  logic                  end_enc = 1'b0;
  logic                  end_dec = 1'b0;
  logic [1:0]            sw_debug = 2'd0;
  logic [31:0]           debug;
  int                    write_count;

  logic [31:0]           rng;
  logic [BLOCK_BITS-1:0] row_block [ROWS];
  logic [KEY_BITS-1:0]   row_key [ROWS];
  logic [BLOCK_BITS-1:0] row_expected [ROWS];
  int                    run_cnt = 0;

  autotest_top autotest_top_i (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy),
    .spi_data_out_i   (spi_data_out),
    .spi_err_i        (1'b0),
    .spi_crc_err_i    (1'b0),
    .spi_block_addr_o (spi_block_addr),
    .spi_r_block_o    (spi_r_block),
    .spi_r_byte_o     (spi_r_byte),
    .spi_w_block_o    (spi_w_block),
    .spi_w_byte_o     (spi_w_byte),
    .spi_rst_o        (spi_rst),
    .spi_data_in_o    (spi_data_in),
    .rst_uut_o        (rst_uut),
    .block_i_uut_o    (block_i_uut),
    .key_uut_o        (key_uut),
    .encdec_uut_o     (encdec_uut),
    .block_o_uut_i    (block_o_uut),
    .end_enc_uut_i    (end_enc),
    .end_dec_uut_i    (end_dec),
    .sw_debug_i       (sw_debug),
    .debug_o          (debug)
  );

  tb_sd_card #(.SECTORS(8)) sd_card_i (
    .clk           (clk),
    .rst           (rst),
    .spi_rst_i     (spi_rst),
    .block_addr_i  (spi_block_addr),
    .r_block_i     (spi_r_block),
    .r_byte_i      (spi_r_byte),
    .w_block_i     (spi_w_block),
    .w_byte_i      (spi_w_byte),
    .data_in_i     (spi_data_in),
    .busy_o        (spi_busy),
    .data_out_o    (spi_data_out),
    .write_count_o (write_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // cipher stand-in is block xor low key bits
  function automatic logic [BLOCK_BITS-1:0] model_result(input int r);
    return row_block[r] ^ row_key[r][BLOCK_BITS-1:0];
  endfunction

  // report byte k for row r with lsb first except the signature
  function automatic logic [7:0] report_byte(input int r, input int k);
    logic [31:0]           lat;
    logic [BLOCK_BITS-1:0] res;
    lat = ROW_LAT[r];
    res = model_result(r);
    if (k < OFS_TAG) return RECORD_SIGNATURE[8*(3-k) +: 8];
    if (k == OFS_TAG) return 8'(8'h30 + r);
    if (k < OFS_KEY) return row_block[r][8*(k-OFS_BLOCK) +: 8];
    if (k < OFS_ENCDEC) return row_key[r][8*(k-OFS_KEY) +: 8];
    if (k == OFS_ENCDEC) return {7'b0, ROW_DEC[r]};
    if (k < OFS_RESULT) return row_expected[r][8*(k-OFS_EXPECTED) +: 8];
    if (k < OFS_EXEC) return res[8*(k-OFS_RESULT) +: 8];
    if (k < OFS_EXEC + 4) return lat[8*(k-OFS_EXEC) +: 8];
    return 8'h00;
  endfunction

  task automatic build_sectors();
    int          a;
    logic [31:0] bad_sig;
    bad_sig = 32'h1122_3344;
    for (int r = 0; r < ROWS; r++) begin
      rng = xorshift(rng);
      row_block[r][31:0] = rng;
      rng = xorshift(rng);
      row_block[r][63:32] = rng;
      rng = xorshift(rng);
      row_key[r][31:0] = rng;
      rng = xorshift(rng);
      row_key[r][63:32] = rng;
      rng = xorshift(rng);
      row_key[r][79:64] = rng[15:0];
      row_expected[r] = ROW_GOOD[r] ? model_result(r) : model_result(r) ^ 64'h1;
      for (int k = 0; k < SECTOR_BYTES; k++) begin
        a = r * SECTOR_BYTES + k;
        // filler outside the record
        sd_card_i.rmem[a] = 8'(a ^ (a >> 8) ^ 8'h5A);
        if (k < OFS_RESULT) begin
          sd_card_i.rmem[a] = report_byte(r, k);
        end
        if (k < OFS_TAG && !ROW_SIG[r]) begin
          sd_card_i.rmem[a] = bad_sig[8*(3-k) +: 8];
        end
      end
    end
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // UUT model raising the selected end flag after the row latency
  always @(negedge clk) begin
    int row;
    if (rst_uut) begin
      run_cnt = 0;
      end_enc <= 1'b0;
      end_dec <= 1'b0;
    end else begin
      row = int'(spi_block_addr - START_BLOCK);
      if (row < 0 || row >= ROWS) begin
        $display("UUT started for a block outside the vector table");
        $display("sim failed");
        $fatal(1, "bad run block");
      end else begin
        check_value("block_i_uut_o", 128'(block_i_uut), 128'(row_block[row]));
        check_value("key_uut_o", 128'(key_uut), 128'(row_key[row]));
        check_value("encdec_uut_o", 128'(encdec_uut), 128'(ROW_DEC[row]));
        block_o_uut <= block_i_uut ^ key_uut[BLOCK_BITS-1:0];
        if (run_cnt >= ROW_LAT[row]) begin
          if (encdec_uut) begin
            end_dec <= 1'b1;
          end else begin
            end_enc <= 1'b1;
          end
        end else begin
          run_cnt = run_cnt + 1;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: controller did not halt within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1, "watchdog");
  end

  initial begin
    int exp_err;
    rst = 1'b1;
    rng = 32'd41;
    exp_err = 0;
    build_sectors();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (debug[3:0] != 4'(ST_HALT)) begin
      @(negedge clk);
    end
    check_value("halt debug word", 128'(debug),
                128'({16'(START_BLOCK + 32'(ROWS - 1)), 12'h000, 4'(ST_HALT)}));
    // last row has the bad signature and is never written
    check_value("write count", 128'(write_count), 128'(ROWS - 1));
    for (int r = 0; r < ROWS - 1; r++) begin
      check_value("report block address", 128'(sd_card_i.wr_addr[r]),
                  128'(START_BLOCK + 32'(r)));
      for (int k = 0; k < SECTOR_BYTES; k++) begin
        check_value($sformatf("report byte %0d of row %0d", k, r),
                    128'(sd_card_i.wmem[r*SECTOR_BYTES+k]), 128'(report_byte(r, k)));
      end
      if (!ROW_GOOD[r]) begin
        exp_err = exp_err + 1;
      end
    end
    @(negedge clk);
    sw_debug = 2'd1;
    @(negedge clk);
    check_value("error count", 128'(debug), 128'(exp_err));
    sw_debug = 2'd2;
    @(negedge clk);
    check_value("exec count", 128'(debug), 128'(ROW_LAT[ROWS-2]));
    sw_debug = 2'd3;
    @(negedge clk);
    check_value("halt block address", 128'(debug), 128'(START_BLOCK + 32'(ROWS - 1)));
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- autotest_top.f
autotest_pkg.sv
sd_host_if.sv
sd_port_arbiter.sv
vector_loader.sv
result_reporter.sv
autotest_sequencer.sv
autotest_top.sv
tb_sd_card.sv
tb_autotest.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the autotest testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_autotest \
  -f autotest_top.f -o tb_autotest > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_autotest > sim.log 2>&1
status=$?

if grep -q "sim failed" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0
